// ==== verilog/l2_geom_pkg.sv ====
`default_nettype none

package l2_geom_pkg;

    // Requesters sharing the cache
    localparam int num_cores = 4;

    // Address and data widths
    localparam int addr_width = 16;
    localparam int word_width = 32;

    // Line geometry, 16 bytes per line
    localparam int words_per_line = 4;
    localparam int line_width = 128;

    // Two-way set-associative array with four sets
    localparam int num_sets = 4;
    localparam int num_ways = 2;

    // Address split: tag [15:6], set [5:4], word [3:2], byte [1:0]
    localparam int offset_bits = 4;
    localparam int set_bits = 2;
    localparam int tag_bits = 10;

    typedef logic [1:0] core_idx_t;

    typedef logic [addr_width-1:0] addr_t;

    typedef logic [word_width-1:0] word_t;

    typedef logic [set_bits-1:0] set_idx_t;

    typedef logic [tag_bits-1:0] tag_t;

    typedef logic way_idx_t;

    typedef logic [1:0] word_idx_t;

    // One cache line, seen flat on the memory side or as words
    // Word 0 sits in the low 32 bits
    typedef union packed {
        logic [line_width-1:0] flat;
        word_t [words_per_line-1:0] words;
    } line_u;

endpackage

`default_nettype wire

// ==== verilog/l2_ctrl_pkg.sv ====
`default_nettype none

package l2_ctrl_pkg;

    // Access sequencing of the cache controller
    typedef enum logic [2:0] {
        idle       = 3'd0,
        arbitrate  = 3'd1,
        check_tag  = 3'd2,
        write_back = 3'd3,
        fetch_line = 3'd4,
        respond    = 3'd5
    } ctrl_state_t;

    // Statistics counters
    localparam int count_width = 32;

    typedef logic [count_width-1:0] count_t;

endpackage

`default_nettype wire

// ==== verilog/l2_ifs.sv ====
`timescale 1ns/1ps
`default_nettype none

// Granted request handed from the arbiter to the controller
interface grant_if;
    logic                   take;
    logic                   retire;
    logic                   any_req;
    l2_geom_pkg::core_idx_t core;
    l2_geom_pkg::addr_t     addr;
    l2_geom_pkg::word_t     wdata;
    logic                   write;

    modport arbiter (input take, retire, output any_req, core, addr, wdata, write);
    modport controller (output take, retire, input any_req, core, addr, wdata, write);
endinterface

// Controller access to the tag and data storage
interface array_if;
    l2_geom_pkg::set_idx_t  set;
    l2_geom_pkg::tag_t      tag;
    logic                   fill_en;
    l2_geom_pkg::way_idx_t  fill_way;
    l2_geom_pkg::line_u     fill_line;
    logic                   fill_dirty;
    logic                   word_en;
    l2_geom_pkg::way_idx_t  word_way;
    l2_geom_pkg::word_idx_t word_idx;
    l2_geom_pkg::word_t     word_data;
    logic                   hit;
    l2_geom_pkg::way_idx_t  hit_way;
    l2_geom_pkg::way_idx_t  victim_way;
    logic                   victim_dirty;
    l2_geom_pkg::tag_t      victim_tag;
    l2_geom_pkg::line_u [l2_geom_pkg::num_ways-1:0] line_of_way;

    modport array (
        input  set, tag, fill_en, fill_way, fill_line, fill_dirty,
        input  word_en, word_way, word_idx, word_data,
        output hit, hit_way, victim_way, victim_dirty, victim_tag, line_of_way
    );
    modport controller (
        output set, tag, fill_en, fill_way, fill_line, fill_dirty,
        output word_en, word_way, word_idx, word_data,
        input  hit, hit_way, victim_way, victim_dirty, victim_tag, line_of_way
    );
endinterface

`default_nettype wire

// ==== verilog/rr_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module rr_arbiter (
    input  wire logic                                         clk,
    input  wire logic                                         rst_n,
    input  wire logic [l2_geom_pkg::num_cores-1:0]            l1_request,
    input  wire logic [l2_geom_pkg::num_cores-1:0]            l1_write,
    input  l2_geom_pkg::addr_t [l2_geom_pkg::num_cores-1:0]   l1_addr,
    input  l2_geom_pkg::word_t [l2_geom_pkg::num_cores-1:0]   l1_wdata,
    grant_if.arbiter                                          gnt
);

    l2_geom_pkg::core_idx_t ptr;
    l2_geom_pkg::core_idx_t pick;
    logic                   found;

    // First requester at or after the pointer, wrapping
    always_comb begin
        l2_geom_pkg::core_idx_t cand;
        pick = ptr;
        found = 1'b0;
        for (int i = 0; i < l2_geom_pkg::num_cores; i++) begin
            cand = ptr + l2_geom_pkg::core_idx_t'(i);
            if (!found && l1_request[cand]) begin
                pick = cand;
                found = 1'b1;
            end
        end
    end

    assign gnt.any_req = |l1_request;

    // Pointer moves on every completed access, independent of the winner
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (gnt.retire) begin
            ptr <= ptr + 1'b1;
        end
    end

    // Granted request held until the next arbitration
    always_ff @(posedge clk) begin
        if (gnt.take) begin
            gnt.core  <= pick;
            gnt.addr  <= l1_addr[pick];
            gnt.wdata <= l1_wdata[pick];
            gnt.write <= l1_write[pick];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/tag_data_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module tag_data_array (
    input  wire logic clk,
    input  wire logic rst_n,
    array_if.array    arr
);

    // Per-set state, one bit per way
    logic [l2_geom_pkg::num_ways-1:0] valid [l2_geom_pkg::num_sets];
    logic [l2_geom_pkg::num_ways-1:0] dirty [l2_geom_pkg::num_sets];

    // Bit set names the least recently used way
    logic [l2_geom_pkg::num_sets-1:0] lru;

    l2_geom_pkg::tag_t  tags  [l2_geom_pkg::num_sets][l2_geom_pkg::num_ways];
    l2_geom_pkg::line_u lines [l2_geom_pkg::num_sets][l2_geom_pkg::num_ways];

    // Tag compare and read-out of the addressed set
    always_comb begin
        arr.hit = 1'b0;
        arr.hit_way = '0;
        for (int w = 0; w < l2_geom_pkg::num_ways; w++) begin
            arr.line_of_way[w] = lines[arr.set][w];
            if (valid[arr.set][w] && tags[arr.set][w] == arr.tag) begin
                arr.hit = 1'b1;
                arr.hit_way = l2_geom_pkg::way_idx_t'(w);
            end
        end
    end

    // Lowest invalid way first, otherwise the LRU way
    always_comb begin
        arr.victim_way = lru[arr.set];
        for (int w = l2_geom_pkg::num_ways - 1; w >= 0; w--) begin
            if (!valid[arr.set][w]) begin
                arr.victim_way = l2_geom_pkg::way_idx_t'(w);
            end
        end
        arr.victim_dirty = valid[arr.set][arr.victim_way] && dirty[arr.set][arr.victim_way];
        arr.victim_tag = tags[arr.set][arr.victim_way];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < l2_geom_pkg::num_sets; s++) begin
                valid[s] <= '0;
                dirty[s] <= '0;
            end
            lru <= '0;
        end else if (arr.fill_en) begin
            valid[arr.set][arr.fill_way] <= 1'b1;
            dirty[arr.set][arr.fill_way] <= arr.fill_dirty;
            lru[arr.set] <= ~arr.fill_way;
        end else if (arr.word_en) begin
            dirty[arr.set][arr.word_way] <= 1'b1;
            lru[arr.set] <= ~arr.word_way;
        end else if (arr.hit) begin
            // Any hit on the addressed line makes the other way LRU
            lru[arr.set] <= ~arr.hit_way;
        end
    end

    // Tag and line storage
    always_ff @(posedge clk) begin
        if (arr.fill_en) begin
            tags[arr.set][arr.fill_way] <= arr.tag;
            lines[arr.set][arr.fill_way] <= arr.fill_line;
        end
        if (arr.word_en) begin
            lines[arr.set][arr.word_way].words[arr.word_idx] <= arr.word_data;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/l2_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module l2_controller (
    input  wire logic                                         clk,
    input  wire logic                                         rst_n,
    grant_if.controller                                       gnt,
    array_if.controller                                       arr,
    output logic [l2_geom_pkg::num_cores-1:0]                 l1_ready,
    output logic [l2_geom_pkg::num_cores-1:0]                 l1_error,
    output l2_geom_pkg::word_t [l2_geom_pkg::num_cores-1:0]   l1_rdata,
    output logic                                              mem_request,
    output logic                                              mem_read,
    output logic                                              mem_write,
    output l2_geom_pkg::addr_t                                mem_addr,
    output logic [l2_geom_pkg::line_width-1:0]                mem_wdata,
    input  wire logic [l2_geom_pkg::line_width-1:0]           mem_rdata,
    input  wire logic                                         mem_ready,
    input  wire logic                                         mem_error,
    output l2_ctrl_pkg::count_t                               hit_count,
    output l2_ctrl_pkg::count_t                               miss_count,
    output l2_ctrl_pkg::count_t                               evict_count
);

    l2_ctrl_pkg::ctrl_state_t state;
    l2_ctrl_pkg::ctrl_state_t next_state;
    l2_geom_pkg::way_idx_t    answer_way;
    logic                     fetch_err;

    // Address fields of the pending request
    assign arr.set = gnt.addr[l2_geom_pkg::offset_bits +: l2_geom_pkg::set_bits];
    assign arr.tag = gnt.addr[l2_geom_pkg::offset_bits + l2_geom_pkg::set_bits +:
                              l2_geom_pkg::tag_bits];
    assign arr.word_idx = gnt.addr[l2_geom_pkg::offset_bits-1 -: $bits(l2_geom_pkg::word_idx_t)];

    assign gnt.take = (state == l2_ctrl_pkg::arbitrate);
    assign gnt.retire = (state == l2_ctrl_pkg::respond);

    // Fetched line goes straight into the victim way
    assign arr.fill_en = (state == l2_ctrl_pkg::fetch_line) && mem_ready && !mem_error;
    assign arr.fill_way = answer_way;
    assign arr.fill_line.flat = mem_rdata;
    assign arr.fill_dirty = gnt.write;

    // Word write lands after the line is present
    assign arr.word_en = (state == l2_ctrl_pkg::respond) && gnt.write && !fetch_err;
    assign arr.word_way = answer_way;
    assign arr.word_data = gnt.wdata;

    always_comb begin
        next_state = state;
        case (state)
            l2_ctrl_pkg::idle: begin
                if (gnt.any_req) begin
                    next_state = l2_ctrl_pkg::arbitrate;
                end
            end
            l2_ctrl_pkg::arbitrate: next_state = l2_ctrl_pkg::check_tag;
            l2_ctrl_pkg::check_tag: begin
                if (arr.hit) begin
                    next_state = l2_ctrl_pkg::respond;
                end else if (arr.victim_dirty) begin
                    next_state = l2_ctrl_pkg::write_back;
                end else begin
                    next_state = l2_ctrl_pkg::fetch_line;
                end
            end
            l2_ctrl_pkg::write_back: begin
                if (mem_ready) begin
                    next_state = l2_ctrl_pkg::fetch_line;
                end
            end
            l2_ctrl_pkg::fetch_line: begin
                if (mem_ready) begin
                    next_state = l2_ctrl_pkg::respond;
                end
            end
            default: next_state = l2_ctrl_pkg::idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= l2_ctrl_pkg::idle;
            fetch_err <= 1'b0;
            hit_count <= '0;
            miss_count <= '0;
            evict_count <= '0;
        end else begin
            state <= next_state;
            case (state)
                l2_ctrl_pkg::arbitrate: fetch_err <= 1'b0;
                l2_ctrl_pkg::check_tag: begin
                    if (arr.hit) begin
                        hit_count <= hit_count + 1'b1;
                    end
                end
                l2_ctrl_pkg::write_back: begin
                    if (mem_ready) begin
                        evict_count <= evict_count + 1'b1;
                    end
                end
                l2_ctrl_pkg::fetch_line: begin
                    if (mem_ready && mem_error) begin
                        fetch_err <= 1'b1;
                    end else if (mem_ready) begin
                        miss_count <= miss_count + 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

    // Hit way on a hit, victim on a miss
    always_ff @(posedge clk) begin
        if (state == l2_ctrl_pkg::check_tag) begin
            answer_way <= arr.hit ? arr.hit_way : arr.victim_way;
        end
    end

    always_comb begin
        mem_request = (state == l2_ctrl_pkg::write_back) || (state == l2_ctrl_pkg::fetch_line);
        mem_write = (state == l2_ctrl_pkg::write_back);
        mem_read = (state == l2_ctrl_pkg::fetch_line);
        mem_wdata = arr.line_of_way[answer_way].flat;
        if (state == l2_ctrl_pkg::write_back) begin
            mem_addr = {arr.victim_tag, arr.set, {l2_geom_pkg::offset_bits{1'b0}}};
        end else begin
            mem_addr = {arr.tag, arr.set, {l2_geom_pkg::offset_bits{1'b0}}};
        end
    end

    // Response to the pending core only
    always_comb begin
        l1_ready = '0;
        l1_error = '0;
        l1_rdata = '0;
        if (state == l2_ctrl_pkg::respond) begin
            l1_ready[gnt.core] = 1'b1;
            l1_error[gnt.core] = fetch_err;
            if (!gnt.write) begin
                l1_rdata[gnt.core] = arr.line_of_way[answer_way].words[arr.word_idx];
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/l2_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module l2_cache (
    input  wire logic                                         clk,
    input  wire logic                                         rst_n,
    // Core side
    input  wire logic [l2_geom_pkg::num_cores-1:0]            l1_request,
    input  wire logic [l2_geom_pkg::num_cores-1:0]            l1_write,
    input  l2_geom_pkg::addr_t [l2_geom_pkg::num_cores-1:0]   l1_addr,
    input  l2_geom_pkg::word_t [l2_geom_pkg::num_cores-1:0]   l1_wdata,
    output l2_geom_pkg::word_t [l2_geom_pkg::num_cores-1:0]   l1_rdata,
    output logic [l2_geom_pkg::num_cores-1:0]                 l1_ready,
    output logic [l2_geom_pkg::num_cores-1:0]                 l1_error,
    // Memory side, one line per transfer
    output logic                                              mem_request,
    output logic                                              mem_read,
    output logic                                              mem_write,
    output l2_geom_pkg::addr_t                                mem_addr,
    output logic [l2_geom_pkg::line_width-1:0]                mem_wdata,
    input  wire logic [l2_geom_pkg::line_width-1:0]           mem_rdata,
    input  wire logic                                         mem_ready,
    input  wire logic                                         mem_error,
    // Statistics
    output l2_ctrl_pkg::count_t                               hit_count,
    output l2_ctrl_pkg::count_t                               miss_count,
    output l2_ctrl_pkg::count_t                               evict_count
);

    grant_if u_gnt ();
    array_if u_arr ();

    rr_arbiter u_arbiter (
        .clk        (clk),
        .rst_n      (rst_n),
        .l1_request (l1_request),
        .l1_write   (l1_write),
        .l1_addr    (l1_addr),
        .l1_wdata   (l1_wdata),
        .gnt        (u_gnt.arbiter)
    );

    tag_data_array u_array (
        .clk   (clk),
        .rst_n (rst_n),
        .arr   (u_arr.array)
    );

    l2_controller u_controller (
        .clk         (clk),
        .rst_n       (rst_n),
        .gnt         (u_gnt.controller),
        .arr         (u_arr.controller),
        .l1_ready    (l1_ready),
        .l1_error    (l1_error),
        .l1_rdata    (l1_rdata),
        .mem_request (mem_request),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_rdata   (mem_rdata),
        .mem_ready   (mem_ready),
        .mem_error   (mem_error),
        .hit_count   (hit_count),
        .miss_count  (miss_count),
        .evict_count (evict_count)
    );

endmodule

`default_nettype wire

// ==== sim/l2_cache_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module l2_cache_properties (
    input wire logic                                clk,
    input wire logic                                rst_n,
    input wire logic                                mem_request,
    input wire logic                                mem_read,
    input wire logic                                mem_write,
    input wire l2_geom_pkg::addr_t                  mem_addr,
    input wire logic                                mem_ready,
    input wire logic [l2_geom_pkg::num_cores-1:0]   l1_ready,
    input wire logic [l2_geom_pkg::num_cores-1:0]   l1_error
);

    // One memory direction at a time
    read_write_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_read && mem_write))
        else $error("mem_read and mem_write are high together");

    // Request, direction and address held until mem_ready
    request_held: assert property (@(posedge clk) disable iff (!rst_n)
        mem_request && !mem_ready |=> mem_request && $stable(mem_addr) && $stable(mem_write))
        else $error("memory request changed before mem_ready");

    ready_one_core: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(l1_ready))
        else $error("l1_ready is high for more than one core");

    error_with_ready: assert property (@(posedge clk) disable iff (!rst_n)
        (l1_error & ~l1_ready) == '0)
        else $error("l1_error is high without l1_ready");

endmodule

`default_nettype wire

// ==== sim/l2_cache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module l2_cache_tb;

    // Some 23 accesses of at most 20 cycles each, plus reset, with a wide margin
    localparam int max_cycles = 4000;
    // Request sampled in idle, then arbitrate, check_tag and respond
    localparam int hit_latency = 4;
    localparam int num_lines = 1 << (l2_geom_pkg::addr_width - l2_geom_pkg::offset_bits);
    // Tag 0x155 in set 0
    localparam l2_geom_pkg::addr_t error_addr = 16'h5540;

    logic                                                  clk;
    logic                                                  rst_n;
    logic [l2_geom_pkg::num_cores-1:0]                     l1_request;
    logic [l2_geom_pkg::num_cores-1:0]                     l1_write;
    l2_geom_pkg::addr_t [l2_geom_pkg::num_cores-1:0]       l1_addr;
    l2_geom_pkg::word_t [l2_geom_pkg::num_cores-1:0]       l1_wdata;
    l2_geom_pkg::word_t [l2_geom_pkg::num_cores-1:0]       l1_rdata;
    logic [l2_geom_pkg::num_cores-1:0]                     l1_ready;
    logic [l2_geom_pkg::num_cores-1:0]                     l1_error;
    logic                                                  mem_request;
    logic                                                  mem_read;
    logic                                                  mem_write;
    l2_geom_pkg::addr_t                                    mem_addr;
    logic [l2_geom_pkg::line_width-1:0]                    mem_wdata;
    logic [l2_geom_pkg::line_width-1:0]                    mem_rdata;
    logic                                                  mem_ready;
    logic                                                  mem_error;
    l2_ctrl_pkg::count_t                                   hit_count;
    l2_ctrl_pkg::count_t                                   miss_count;
    l2_ctrl_pkg::count_t                                   evict_count;

    // Backing store, and the contents every read should return
    l2_geom_pkg::line_u mem_lines [num_lines];
    l2_geom_pkg::line_u golden [num_lines];
    l2_geom_pkg::line_u last_wb_line;
    l2_geom_pkg::addr_t last_wb_addr;
    int unsigned        wb_count = 0;
    int unsigned        retired = 0;
    int                 cycle_count = 0;
    l2_ctrl_pkg::count_t exp_hits = '0;
    l2_ctrl_pkg::count_t exp_misses = '0;
    l2_ctrl_pkg::count_t exp_evicts = '0;

    l2_cache u_dut (.*);

    bind l2_controller l2_cache_properties u_props (
        .clk         (clk),
        .rst_n       (rst_n),
        .mem_request (mem_request),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .mem_addr    (mem_addr),
        .mem_ready   (mem_ready),
        .l1_ready    (l1_ready),
        .l1_error    (l1_error)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_word(input l2_geom_pkg::word_t actual, expected, input string name);
        if (actual !== expected) begin
            stop_run($sformatf("Mismatch at %0t: %s = %h, expected %h",
                               $time, name, actual, expected));
        end
    endtask

    task automatic check_addr(input l2_geom_pkg::addr_t actual, expected, input string name);
        if (actual !== expected) begin
            stop_run($sformatf("Mismatch at %0t: %s = %h, expected %h",
                               $time, name, actual, expected));
        end
    endtask

    task automatic check_count(input l2_ctrl_pkg::count_t actual, expected, input string name);
        if (actual !== expected) begin
            stop_run($sformatf("Mismatch at %0t: %s = %0d, expected %0d",
                               $time, name, actual, expected));
        end
    endtask

    task automatic check_flag(input logic actual, expected, input string name);
        if (actual !== expected) begin
            stop_run($sformatf("Mismatch at %0t: %s = %b, expected %b",
                               $time, name, actual, expected));
        end
    endtask

    function automatic l2_geom_pkg::addr_t make_addr(input l2_geom_pkg::tag_t tag,
                                                     input l2_geom_pkg::set_idx_t set,
                                                     input l2_geom_pkg::word_idx_t word);
        return {tag, set, word, 2'b00};
    endfunction

    function automatic int line_of(input l2_geom_pkg::addr_t addr);
        return int'(addr) >> l2_geom_pkg::offset_bits;
    endfunction

    function automatic l2_geom_pkg::word_t expected_word(input l2_geom_pkg::addr_t addr);
        return golden[line_of(addr)].words[addr[3:2]];
    endfunction

    task automatic check_counters();
        @(negedge clk);
        check_count(hit_count, exp_hits, "hit_count");
        check_count(miss_count, exp_misses, "miss_count");
        check_count(evict_count, exp_evicts, "evict_count");
    endtask

    // One core access, held until its ready pulse
    task automatic access(input l2_geom_pkg::core_idx_t core, input logic write,
                          input l2_geom_pkg::addr_t addr, input l2_geom_pkg::word_t wdata,
                          output l2_geom_pkg::word_t rdata, output logic err,
                          output int unsigned cycles);
        @(posedge clk);
        l1_request[core] <= 1'b1;
        l1_write[core] <= write;
        l1_addr[core] <= addr;
        l1_wdata[core] <= wdata;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!l1_ready[core]);
        rdata = l1_rdata[core];
        err = l1_error[core];
        @(posedge clk);
        l1_request[core] <= 1'b0;
        retired++;
        if (write && !err) begin
            golden[line_of(addr)].words[addr[3:2]] = wdata;
        end
    endtask

    task automatic read_check(input l2_geom_pkg::core_idx_t core,
                              input l2_geom_pkg::addr_t addr, input string name);
        l2_geom_pkg::word_t rdata;
        logic err;
        int unsigned cycles;
        access(core, 1'b0, addr, '0, rdata, err, cycles);
        check_flag(err, 1'b0, {name, " l1_error"});
        check_word(rdata, expected_word(addr), {name, " l1_rdata"});
    endtask

    task automatic write_check(input l2_geom_pkg::core_idx_t core, input l2_geom_pkg::addr_t addr,
                               input l2_geom_pkg::word_t data, input string name);
        l2_geom_pkg::word_t rdata;
        logic err;
        int unsigned cycles;
        access(core, 1'b1, addr, data, rdata, err, cycles);
        check_flag(err, 1'b0, {name, " l1_error"});
    endtask

    task automatic miss_then_hit();
        l2_geom_pkg::addr_t addr;
        l2_geom_pkg::word_t rdata;
        logic err;
        int unsigned cycles;
        addr = make_addr(10'h011, 2'd0, 2'd2);
        read_check(2'd0, addr, "test1 miss");
        exp_misses += 1;
        check_counters();
        access(2'd1, 1'b0, addr, '0, rdata, err, cycles);
        check_flag(err, 1'b0, "test1 hit l1_error");
        check_word(rdata, expected_word(addr), "test1 hit l1_rdata");
        check_count(l2_ctrl_pkg::count_t'(cycles), hit_latency, "test1 hit latency");
        exp_hits += 1;
        check_counters();
    endtask

    task automatic write_then_read();
        l2_geom_pkg::addr_t base;
        base = make_addr(10'h022, 2'd1, 2'd0);
        write_check(2'd1, base + 16'd4, $urandom, "test2 write");
        exp_misses += 1;
        // Written word comes back, the rest of the line is untouched
        for (int w = 0; w < l2_geom_pkg::words_per_line; w++) begin
            read_check(l2_geom_pkg::core_idx_t'(w), base + l2_geom_pkg::addr_t'(4 * w),
                       $sformatf("test2 word %0d", w));
        end
        exp_hits += 4;
        check_counters();
    endtask

    task automatic dirty_write_back();
        l2_geom_pkg::addr_t a_addr;
        int unsigned wb_before;
        a_addr = make_addr(10'h031, 2'd2, 2'd1);
        write_check(2'd0, a_addr, $urandom, "test3 write a");
        write_check(2'd1, make_addr(10'h032, 2'd2, 2'd3), $urandom, "test3 write b");
        wb_before = wb_count;
        // Both ways dirty, A is the LRU way
        read_check(2'd2, make_addr(10'h033, 2'd2, 2'd0), "test3 read c");
        exp_misses += 3;
        exp_evicts += 1;
        check_counters();
        check_count(l2_ctrl_pkg::count_t'(wb_count - wb_before), 1, "test3 memory writes");
        check_addr(last_wb_addr, make_addr(10'h031, 2'd2, 2'd0), "test3 write-back mem_addr");
        for (int w = 0; w < l2_geom_pkg::words_per_line; w++) begin
            check_word(last_wb_line.words[w], golden[line_of(a_addr)].words[w],
                       $sformatf("test3 write-back word %0d", w));
        end
    endtask

    task automatic lru_victim();
        l2_geom_pkg::addr_t d_addr;
        l2_geom_pkg::addr_t e_addr;
        d_addr = make_addr(10'h041, 2'd3, 2'd0);
        e_addr = make_addr(10'h042, 2'd3, 2'd1);
        read_check(2'd0, d_addr, "test4 d");
        read_check(2'd1, e_addr, "test4 e");
        // D touched after E, so E goes
        read_check(2'd2, d_addr, "test4 d touch");
        read_check(2'd3, make_addr(10'h043, 2'd3, 2'd2), "test4 f");
        exp_misses += 3;
        exp_hits += 1;
        check_counters();
        read_check(2'd0, d_addr, "test4 d kept");
        exp_hits += 1;
        check_counters();
        read_check(2'd1, e_addr, "test4 e refetched");
        exp_misses += 1;
        check_counters();
    endtask

    task automatic four_core_order();
        l2_geom_pkg::addr_t addrs [l2_geom_pkg::num_cores];
        l2_geom_pkg::core_idx_t next_core;
        int served;
        // Extra access moves the pointer off a multiple of four
        read_check(2'd2, make_addr(10'h011, 2'd0, 2'd0), "test5 pointer step");
        addrs[0] = make_addr(10'h011, 2'd0, 2'd1);
        addrs[1] = make_addr(10'h022, 2'd1, 2'd1);
        addrs[2] = make_addr(10'h033, 2'd2, 2'd3);
        addrs[3] = make_addr(10'h041, 2'd3, 2'd0);
        next_core = l2_geom_pkg::core_idx_t'(retired % l2_geom_pkg::num_cores);
        @(posedge clk);
        for (int c = 0; c < l2_geom_pkg::num_cores; c++) begin
            l1_request[c] <= 1'b1;
            l1_write[c] <= 1'b0;
            l1_addr[c] <= addrs[c];
        end
        served = 0;
        while (served < l2_geom_pkg::num_cores) begin
            @(negedge clk);
            if (l1_ready != '0) begin
                for (int c = 0; c < l2_geom_pkg::num_cores; c++) begin
                    check_flag(l1_ready[c], c == int'(next_core),
                               $sformatf("test5 l1_ready[%0d]", c));
                end
                check_word(l1_rdata[next_core], expected_word(addrs[next_core]),
                           "test5 l1_rdata");
                @(posedge clk);
                l1_request[next_core] <= 1'b0;
                next_core = next_core + 1'b1;
                served++;
                retired++;
            end
        end
        exp_hits += 5;
        check_counters();
    endtask

    task automatic fetch_error();
        l2_geom_pkg::word_t rdata;
        logic err;
        int unsigned cycles;
        // Nothing is filled, so the retry misses and fails again
        for (int n = 0; n < 2; n++) begin
            access(2'd3, 1'b0, error_addr + 16'd8, '0, rdata, err, cycles);
            check_flag(err, 1'b1, "test6 l1_error");
            check_counters();
        end
    endtask

    // Memory with 1 to 4 cycles of latency and one failing line
    initial begin : memory_model
        int unsigned        delay;
        l2_geom_pkg::addr_t req_addr;
        logic               req_write;
        l2_geom_pkg::line_u req_line;
        mem_ready = 1'b0;
        mem_error = 1'b0;
        mem_rdata = '0;
        forever begin
            @(negedge clk);
            if (rst_n && mem_request) begin
                req_addr = mem_addr;
                req_write = mem_write;
                req_line.flat = mem_wdata;
                check_flag(mem_read, !mem_write, "mem_read");
                if (req_addr[l2_geom_pkg::offset_bits-1:0] != '0) begin
                    stop_run("Memory request address is not line-aligned");
                end
                delay = 1 + ($urandom % 4);
                repeat (delay - 1) @(negedge clk);
                @(posedge clk);
                if (req_write) begin
                    mem_lines[line_of(req_addr)] = req_line;
                    last_wb_addr = req_addr;
                    last_wb_line = req_line;
                    wb_count++;
                end
                mem_ready <= 1'b1;
                mem_error <= !req_write && (req_addr == error_addr);
                mem_rdata <= mem_lines[line_of(req_addr)].flat;
                @(posedge clk);
                mem_ready <= 1'b0;
                mem_error <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            stop_run("Timeout: the tests did not finish within the cycle limit");
        end
    end

    initial begin
        rst_n = 1'b0;
        l1_request = '0;
        l1_write = '0;
        l1_addr = '0;
        l1_wdata = '0;
        void'($urandom(32'hdd70_da86));
        for (int i = 0; i < num_lines; i++) begin
            for (int w = 0; w < l2_geom_pkg::words_per_line; w++) begin
                mem_lines[i].words[w] = $urandom;
            end
            golden[i] = mem_lines[i];
        end
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        check_counters();
        miss_then_hit();
        write_then_read();
        dirty_write_back();
        lru_victim();
        four_core_order();
        fetch_error();
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
verilog/l2_geom_pkg.sv
verilog/l2_ctrl_pkg.sv
verilog/l2_ifs.sv
verilog/rr_arbiter.sv
verilog/tag_data_array.sv
verilog/l2_controller.sv
verilog/l2_cache.sv
sim/l2_cache_properties.sv
sim/l2_cache_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the L2 cache testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module l2_cache_tb \
    -o l2_cache_sim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/l2_cache_sim > sim.log 2>&1
cat sim.log
grep -q "Test failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "Test completed successfully" sim.log && echo "Simulation PASSED" || { echo "No result in sim.log"; exit 1; }
